//--- bench/tb_model.svh
// reference butterfly model, expected beat queue and the single compare task
// the including module must import ntt_params_pkg and ntt_types_pkg first
// compare failures go through abort_run of the including module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef logic [$bits(out_beat_t)-1:0] cmp_t;   // widest value ever compared

coef_beat_t exp_q [$];  // expected output beats, oldest first
int         errors = 0;

// lane l: even + k*odd and even - k*odd, both mod q, input word layout kept
function automatic coef_beat_t model_beat(input coef_beat_t in_b, input key_vec_t key);
    coef_beat_t      res;
    longint unsigned e;
    longint unsigned t;
    for (int l = 0; l < lanes; l++) begin
        e = 64'(in_b.w[2*l]);
        t = (64'(key.k[l]) * 64'(in_b.w[2*l+1])) % q_mod;
        res.w[2*l]   = coef_t'((e + t) % q_mod);
        res.w[2*l+1] = coef_t'((e + q_mod - t) % q_mod);  // kept non-negative
    end
    return res;
endfunction

task automatic check_equal(input cmp_t got, input cmp_t expected, input string what);
    if (got !== expected) begin
        errors++;
        abort_run($sformatf("FAILED at %0t ns: %s, got %h expected %h",
                            $time, what, got, expected));
    end
endtask

`endif

//--- bench/tb_ntt_pointwise.sv
// random frames through ntt_pointwise_top, checked beat by beat against a model
// one single frame, then twenty back-to-back frames with input gaps and output stalls
// stops at the first mismatch or timeout
`timescale 1ns/100ps

module tb_ntt_pointwise
    import ntt_params_pkg::*, ntt_types_pkg::*;
();

    localparam int wait_limit  = 200;   // cycles for one input beat to be taken
    localparam int drain_limit = 1000;  // cycles for all queued results
    localparam int n_frames    = 20;

    logic       clk;
    logic       reset;
    logic       in_valid;
    coef_beat_t in_beat;
    key_vec_t   secret_key;
    logic       out_ready;
    logic       in_ready;
    logic       out_valid;
    out_beat_t  out_beat;

    ntt_pointwise_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .secret_key (secret_key),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "tb_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // about one word in four is an edge value
    function automatic coef_t rand_coef();
        int unsigned r;
        r = $urandom % 8;
        if (r == 0)
            return '0;
        if (r == 1)
            return coef_t'(q_mod - 1);
        return coef_t'($urandom % q_mod);
    endfunction

    // entered and left at 1 ns after a rising edge
    task automatic send_beat(input coef_beat_t beat);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_beat  = beat;
        while (!in_ready) begin  // beat held until taken
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit)
                abort_run("timeout: input beat was never accepted");
        end
        @(posedge clk);          // transfer edge
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_frame();
        coef_beat_t beats [bank_depth];
        key_vec_t   key;
        for (int l = 0; l < lanes; l++)
            key.k[l] = rand_coef();
        for (int b = 0; b < bank_depth; b++) begin
            for (int w = 0; w < beat_words; w++)
                beats[b].w[w] = rand_coef();
            exp_q.push_back(model_beat(beats[b], key));
        end
        for (int b = 0; b < bank_depth; b++) begin
            repeat ($urandom % 3) begin   // random input gap
                @(posedge clk);
                #1;
            end
            if (b == 0)
                secret_key = key;         // sampled with the first beat
            send_beat(beats[b]);
        end
    endtask

    // random back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($urandom % 4) != 0;
        end
    end

    // sampled on the falling edge, where everything is settled
    initial begin : monitor
        out_beat_t  held;
        coef_beat_t exp_b;
        logic       stalled;
        logic       busy;       // eighth beat in, last beat not yet out
        int         beat_idx;
        int         in_count;
        stalled  = 1'b0;
        busy     = 1'b0;
        beat_idx = 0;
        in_count = 0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (stalled) begin
                    check_equal(cmp_t'(out_valid), cmp_t'(1), "out_valid dropped in a stall");
                    check_equal(cmp_t'(out_beat), cmp_t'(held), "out_beat moved in a stall");
                end
                if (busy)
                    check_equal(cmp_t'(in_ready), cmp_t'(0), "in_ready high in a busy frame");
                if (in_valid && in_ready) begin
                    in_count++;
                    if (in_count % bank_depth == 0)
                        busy = 1'b1;
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0)
                        abort_run("output beat transferred with no frame expected");
                    exp_b = exp_q.pop_front();
                    check_equal(cmp_t'(out_beat.data), cmp_t'(exp_b), "output beat data");
                    check_equal(cmp_t'(out_beat.last), cmp_t'(beat_idx == last_addr),
                                "last flag");
                    if (beat_idx == last_addr) begin
                        beat_idx = 0;
                        busy     = 1'b0;
                    end else begin
                        beat_idx++;
                    end
                end
                stalled = out_valid && !out_ready;
                held    = out_beat;
            end
        end
    end

    initial begin : stimulus
        int waited;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_beat    = '0;
        secret_key = '0;
        out_ready  = 1'b0;
        void'($urandom(22));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_equal(cmp_t'(out_valid), cmp_t'(0), "out_valid after reset");
        check_equal(cmp_t'(in_ready), cmp_t'(1), "in_ready after reset");
        send_frame();                 // single frame first
        repeat (n_frames) send_frame();
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > drain_limit)
                abort_run("timeout: expected output beats never arrived");
        end
        if (errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- butterfly_lane/butterfly_lane.sv
// one lane: eight-pair bank plus a three-stage modular butterfly
// even must be below q_mod; the key word may be any 16-bit value
// results replace the issued pair exactly lane_lat cycles after issue
`timescale 1ns/100ps

module butterfly_lane
    import ntt_params_pkg::*, ntt_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  lane_cmd_t  lane_cmd,
    input  lane_pair_t load_pair,
    input  coef_t      lane_key,
    input  addr_t      rd_addr,
    output lane_pair_t rd_pair
);

    typedef struct packed {
        addr_t addr;
        coef_t even;
        prod_t prod;    // key * odd, unreduced
    } s1_t;

    typedef struct packed {
        addr_t addr;
        coef_t even;
        coef_t red;     // key * odd mod q
    } s2_t;

    typedef struct packed {
        addr_t      addr;
        lane_pair_t pair;   // {even + t, even - t}
    } s3_t;

    lane_pair_t          bank [bank_depth];
    lane_pair_t          src;
    logic [lane_lat-1:0] vld;   // vld[i] qualifies stage i+1
    s1_t                 s1;
    s2_t                 s2;
    s3_t                 s3;
    coef_t               sum_raw;
    coef_t               sum_mod;
    coef_t               diff_mod;

    assign src     = bank[lane_cmd.addr];   // issue read port
    assign rd_pair = bank[rd_addr];         // collector read port

    // both operands below q, so one correction each
    always_comb begin
        sum_raw  = s2.even + s2.red;
        sum_mod  = (sum_raw >= coef_t'(q_mod)) ? sum_raw - coef_t'(q_mod) : sum_raw;
        diff_mod = (s2.even >= s2.red) ? s2.even - s2.red
                                       : s2.even + coef_t'(q_mod) - s2.red;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            vld <= '0;
        else
            vld <= {vld[lane_lat-2:0], lane_cmd.issue};
    end

    always_ff @(posedge clk) begin
        s1.addr <= lane_cmd.addr;
        s1.even <= src.even;
        s1.prod <= prod_t'(lane_key) * prod_t'(src.odd);
        s2.addr <= s1.addr;
        s2.even <= s1.even;
        s2.red  <= coef_t'(s1.prod % prod_t'(q_mod));   // plain constant reduction
        s3.addr <= s2.addr;
        s3.pair <= '{even: sum_mod, odd: diff_mod};
    end

    // load and write-back share the bank write port
    always_ff @(posedge clk) begin
        if (lane_cmd.load_we)
            bank[lane_cmd.addr] <= load_pair;
        if (vld[lane_lat-1])
            bank[s3.addr] <= s3.pair;   // in place, same address as issued
    end

    // sequencer keeps loading and the pipe tail apart in time
    a_no_write_clash: assert property (@(posedge clk) disable iff (reset)
        !(lane_cmd.load_we && vld[lane_lat-1]));

endmodule

//--- common/ntt_params_pkg.sv
// sizes and the modulus for the 64-point pointwise butterfly datapath
// every coefficient entering the datapath must already be below q_mod
// lane_lat is tied to the three registered stages of butterfly_lane

package ntt_params_pkg;

    // frame geometry
    localparam int lanes      = 4;                      // butterfly lanes
    localparam int ring_size  = 64;                     // coefficients per frame
    localparam int beat_words = 2 * lanes;              // even+odd word per lane
    localparam int bank_depth = ring_size / beat_words; // pairs per lane, beats per frame
    localparam int last_addr  = bank_depth - 1;         // final beat / issue address

    // arithmetic
    localparam int q_mod  = 12289;                      // prime modulus
    localparam int coef_w = 16;                         // 14 bits needed, 16 stored
    localparam int addr_w = $clog2(bank_depth);         // 3 bits

    // timing
    localparam int lane_lat = 3;                        // issue to write-back, cycles
    localparam int drain_w  = $clog2(lane_lat);         // drain counter width

    // one coefficient or key word
    typedef logic [coef_w-1:0] coef_t;

    // key times odd before reduction
    typedef logic [2*coef_w-1:0] prod_t;

    // bank address, also the beat index
    typedef logic [addr_w-1:0] addr_t;

endpackage

//--- common/ntt_types_pkg.sv
// stream beats, lane commands and the sequencer states
// beat word 2l feeds lane l as even, word 2l+1 as odd

package ntt_types_pkg;
    import ntt_params_pkg::*;

    // one wide stream beat, word 0 in the low bits
    typedef struct packed {
        coef_t [beat_words-1:0] w;
    } coef_beat_t;

    typedef struct packed {
        logic       last;   // final beat of a frame
        coef_beat_t data;
    } out_beat_t;

    // one bank entry
    typedef struct packed {
        coef_t even;
        coef_t odd;
    } lane_pair_t;

    // broadcast to every lane
    typedef struct packed {
        logic  load_we; // write load_pair at addr
        logic  issue;   // start a butterfly on addr
        addr_t addr;
    } lane_cmd_t;

    typedef struct packed {
        coef_t [lanes-1:0] k;   // k[l] is lane l's key
    } key_vec_t;

    typedef enum logic [1:0] {load, compute, drain, unload} seq_state_t;

endpackage

//--- design/ntt_pointwise_top.sv
// pointwise butterfly engine, eight input beats in and eight output beats out per frame
// in_ready stays low from the eighth input beat until the last output beat transfers
// coefficients must be below q_mod
`timescale 1ns/100ps

module ntt_pointwise_top
    import ntt_params_pkg::*, ntt_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  coef_beat_t in_beat,
    input  key_vec_t   secret_key,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       out_valid,
    output out_beat_t  out_beat
);

    lane_cmd_t  lane_cmd;
    key_vec_t   lane_key;
    logic       unload_go;
    logic       unload_done;
    addr_t      rd_addr;
    lane_pair_t load_pair [lanes];
    lane_pair_t rd_pair   [lanes];

    ntt_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .secret_key  (secret_key),
        .unload_done (unload_done),
        .in_ready    (in_ready),
        .lane_cmd    (lane_cmd),
        .lane_key    (lane_key),
        .unload_go   (unload_go)
    );

    for (genvar l = 0; l < lanes; l++) begin : g_lane
        assign load_pair[l].even = in_beat.w[2*l];
        assign load_pair[l].odd  = in_beat.w[2*l+1];

        butterfly_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .lane_cmd  (lane_cmd),     // same command to every lane
            .load_pair (load_pair[l]),
            .lane_key  (lane_key.k[l]),
            .rd_addr   (rd_addr),
            .rd_pair   (rd_pair[l])
        );
    end

    result_collector u_coll (
        .clk         (clk),
        .reset       (reset),
        .unload_go   (unload_go),
        .rd_pair     (rd_pair),
        .out_ready   (out_ready),
        .rd_addr     (rd_addr),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .unload_done (unload_done)
    );

endmodule

//--- design/ntt_sequencer.sv
// frame control: load eight beats, issue eight butterflies, wait out the pipe
// then hand the banks to the collector until it reports the last transfer
// the key is taken from secret_key on the first accepted beat of a frame
`timescale 1ns/100ps

module ntt_sequencer
    import ntt_params_pkg::*, ntt_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  key_vec_t  secret_key,
    input  logic      unload_done,
    output logic      in_ready,
    output lane_cmd_t lane_cmd,
    output key_vec_t  lane_key,
    output logic      unload_go
);

    seq_state_t          state;
    addr_t               cnt;        // beat index in load, issue address in compute
    logic [drain_w-1:0]  drain_cnt;  // cycles spent in drain
    key_vec_t            key_q;
    logic                accept;

    assign in_ready = (state == load);
    assign accept   = in_valid && in_ready;

    // write lands on the same edge that takes the beat
    always_comb begin
        lane_cmd.load_we = accept;
        lane_cmd.issue   = (state == compute);
        lane_cmd.addr    = cnt;
    end

    // last drain cycle, final write-back lands on this edge
    assign unload_go = (state == drain) && (drain_cnt == drain_w'(lane_lat - 1));

    assign lane_key = key_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= load;
            cnt       <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                load: begin
                    if (accept) begin
                        cnt <= cnt + 1'b1;   // wraps to 0 after the eighth beat
                        if (cnt == addr_t'(last_addr))
                            state <= compute;
                    end
                end
                compute: begin
                    cnt <= cnt + 1'b1;       // one pair per cycle
                    if (cnt == addr_t'(last_addr)) begin
                        state     <= drain;
                        drain_cnt <= '0;
                    end
                end
                drain: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (unload_go)
                        state <= unload;
                end
                unload: begin
                    if (unload_done)     // last beat left the collector
                        state <= load;
                end
                default: state <= load;
            endcase
        end
    end

    // key is held for the whole frame
    always_ff @(posedge clk) begin
        if (accept && cnt == '0)
            key_q <= secret_key;
    end

    // ready comes back only after the collector finished
    a_ready_after_unload: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ready) |-> $past(unload_done));

endmodule

//--- design/result_collector.sv
// reads the lane banks one address per beat into a single output register
// beat data holds while out_ready is low; last is set on address last_addr
`timescale 1ns/100ps

module result_collector
    import ntt_params_pkg::*, ntt_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       unload_go,
    input  lane_pair_t rd_pair [lanes],
    input  logic       out_ready,
    output addr_t      rd_addr,
    output logic       out_valid,
    output out_beat_t  out_beat,
    output logic       unload_done
);

    addr_t      addr_q;
    logic       valid_q;
    out_beat_t  beat_q;
    coef_beat_t rd_beat;
    logic       xfer;
    logic       load_en;

    // lane l back into words 2l and 2l+1
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            rd_beat.w[2*l]   = rd_pair[l].even;
            rd_beat.w[2*l+1] = rd_pair[l].odd;
        end
    end

    assign xfer        = valid_q && out_ready;
    assign load_en     = !valid_q || xfer;  // register free or emptying
    assign unload_done = xfer && beat_q.last;
    assign rd_addr     = addr_q;
    assign out_valid   = valid_q;
    assign out_beat    = beat_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            if (unload_go)
                valid_q <= 1'b1;
            else if (unload_done)
                valid_q <= 1'b0;
            if (unload_go || (xfer && !beat_q.last))
                addr_q <= addr_q + 1'b1;    // back to 0 once beat 7 is loaded
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            beat_q.data <= rd_beat;
            beat_q.last <= (addr_q == addr_t'(last_addr));
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

//--- ntt_pointwise.f
+incdir+bench
common/ntt_params_pkg.sv
common/ntt_types_pkg.sv
butterfly_lane/butterfly_lane.sv
design/ntt_sequencer.sv
design/result_collector.sv
design/ntt_pointwise_top.sv
bench/tb_ntt_pointwise.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f ntt_pointwise.f \
    --top-module tb_ntt_pointwise \
    -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_ntt_pointwise > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q ">>> FAIL" "$SIM_LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0
